/* ccm_decode.sv */
/*
 * decode stage
 * effective address adder, range and region check, stage register
 */

`timescale 1ns/1ps

module ccm_decode (
   input  logic                      clk,
   input  logic                      rst_l,
   input  ccm_ecc_pkg::ccm_req_t     req,
   output ccm_ecc_pkg::ccm_dec_pkt_t dec
);

   localparam int AW = ccm_map_pkg::ADDR_W;
   localparam int OW = ccm_map_pkg::OFFSET_W;
   localparam int RB = ccm_map_pkg::REGION_BITS;
   localparam int MB = ccm_map_pkg::MASK_BITS;
   localparam logic [AW-1:0] BASE = ccm_map_pkg::CCM_SADR;

   logic [AW-1:0] addr;
   logic [OW-1:0] addr_lo;
   logic [AW-1:OW] addr_hi;
   logic [AW-1:OW] rs1_inc;
   logic [AW-1:OW] rs1_dec;
   logic          cout;
   logic          sign;
   logic          in_range;
   logic          in_region;

   // low part is a plain add, the upper part only needs +1, -1 or nothing
   assign {cout, addr_lo} = {1'b0, req.rs1[OW-1:0]} + {1'b0, req.offset};

   assign rs1_inc = req.rs1[AW-1:OW] + 1'b1;
   assign rs1_dec = req.rs1[AW-1:OW] - 1'b1;
   assign sign    = req.offset[OW-1];

   assign addr_hi = ({(AW-OW){ sign ~^ cout}} & req.rs1[AW-1:OW]) |
                    ({(AW-OW){~sign &  cout}} & rs1_inc) |   // positive offset, carry out
                    ({(AW-OW){ sign & ~cout}} & rs1_dec);    // negative offset, borrow

   assign addr = {addr_hi, addr_lo};

   // range and region compare against the base
   assign in_region = (addr[AW-1:AW-RB] == BASE[AW-1:AW-RB]);
   assign in_range  = (addr[AW-1:MB] == BASE[AW-1:MB]);

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         dec <= '0;
      end else begin
         dec.valid  <= req.valid;
         dec.store  <= req.store;
         dec.fault  <= ~in_range;
         dec.region <= in_region;
         dec.index  <= addr[ccm_map_pkg::INDEX_W+1:2];   // word index, byte bits dropped
         dec.wdata  <= req.wdata;
         dec.flip   <= req.flip;
      end
   end

endmodule : ccm_decode

/* ccm_ecc_pkg.sv */
/*
 * SECDED codeword and pipeline packets of the memory path
 * 39-bit codeword, request, stage packets, response
 * check-bit generator for 32 data bits
 */

package ccm_ecc_pkg;

   localparam int DATA_W = 32;
   localparam int ECC_W  = 7;
   localparam int CW_W   = DATA_W + ECC_W;

   // stored word, check bits above the data
   typedef struct packed {
      logic [ECC_W-1:0]  ecc;
      logic [DATA_W-1:0] data;
   } ccm_cw_t;

   // load or store request, one per cycle
   typedef struct packed {
      logic                                valid;
      logic                                store;
      logic [ccm_map_pkg::ADDR_W-1:0]      rs1;
      logic [ccm_map_pkg::OFFSET_W-1:0]    offset;
      logic [DATA_W-1:0]                   wdata;
      logic [CW_W-1:0]                     flip;   // error injection mask
   } ccm_req_t;

   // decode -> execute
   typedef struct packed {
      logic                                valid;
      logic                                store;
      logic                                fault;   // address outside the window
      logic                                region;
      logic [ccm_map_pkg::INDEX_W-1:0]     index;
      logic [DATA_W-1:0]                   wdata;
      logic [CW_W-1:0]                     flip;
   } ccm_dec_pkt_t;

   // execute -> result
   typedef struct packed {
      logic                                valid;
      logic                                fault;
      logic                                region;
      ccm_cw_t                             cw;     // raw codeword from the array
   } ccm_exe_pkt_t;

   typedef struct packed {
      logic                                valid;
      logic                                fault;
      logic                                region;
      logic                                single_err;
      logic                                double_err;
      logic [DATA_W-1:0]                   rdata;
   } ccm_rsp_t;

   // hamming bits [5:0] plus overall parity in bit 6
   // data bits fill the codeword positions 3,5,6,7,9.. skipping powers of two,
   // check bit k covers every position with bit k set
   function automatic logic [ECC_W-1:0] ccm_ecc_gen(input logic [DATA_W-1:0] d);
      logic [ECC_W-2:0] h;
      logic [5:0]       pos;
      h   = '0;
      pos = 6'd3;
      for (int i = 0; i < DATA_W; i++) begin
         if ((pos & (pos - 6'd1)) == 6'd0)
            pos = pos + 6'd1;   // slot held by a check bit
         for (int k = 0; k < ECC_W - 1; k++) begin
            if (pos[k])
               h[k] = h[k] ^ d[i];
         end
         pos = pos + 6'd1;
      end
      return {(^d) ^ (^h), h};
   endfunction

endpackage : ccm_ecc_pkg

/* ccm_execute.sv */
/*
 * execute stage
 * SECDED encode of store data, flip mask injection,
 * 16-word codeword array and read register
 */

`timescale 1ns/1ps

module ccm_execute (
   input  logic                      clk,
   input  logic                      rst_l,
   input  ccm_ecc_pkg::ccm_dec_pkt_t dec,
   output ccm_ecc_pkg::ccm_exe_pkt_t exe
);

   // codeword storage, not reset
   ccm_ecc_pkg::ccm_cw_t mem [0:ccm_map_pkg::DEPTH-1];

   ccm_ecc_pkg::ccm_cw_t wr_cw;
   logic [ccm_ecc_pkg::ECC_W-1:0] wr_ecc;
   logic                 wr_en;
   logic                 rsp_req;

   assign wr_ecc = ccm_ecc_pkg::ccm_ecc_gen(dec.wdata);

   // flip inverts selected codeword bits on the way in
   assign wr_cw = {wr_ecc, dec.wdata} ^ dec.flip;

   // faulting stores must not touch the array
   assign wr_en = dec.valid & dec.store & ~dec.fault;

   // loads and every fault get a response
   assign rsp_req = dec.valid & (~dec.store | dec.fault);

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[dec.index] <= wr_cw;
   end

   // read register, sees older stores only
   // a store in the same cycle cannot target this request
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         exe <= '0;
      end else begin
         exe.valid  <= rsp_req;
         exe.fault  <= dec.fault;
         exe.region <= dec.region;
         exe.cw     <= mem[dec.index];
      end
   end

endmodule : ccm_execute

/* ccm_map_pkg.sv */
/*
 * address map of the closely-coupled data memory
 * base address, region and range widths, array geometry
 */

package ccm_map_pkg;

   // bus widths
   localparam int ADDR_W   = 32;
   localparam int OFFSET_W = 12;   // signed immediate of a load or store

   // memory placement
   localparam logic [ADDR_W-1:0] CCM_SADR = 32'hF004_0000;
   localparam int CCM_SIZE_KB = 64;

   // upper address bits that name a region
   localparam int REGION_BITS = 4;

   // lowest bit of the range compare, 16 for a 64KB window
   localparam int MASK_BITS = 10 + $clog2(CCM_SIZE_KB);

   // implemented array
   // only address bits 5:2 select a word, the rest of the window aliases
   localparam int DEPTH   = 16;
   localparam int INDEX_W = 4;

endpackage : ccm_map_pkg

/* ccm_result.sv */
/*
 * result stage
 * syndrome, single-bit correction, double-bit detection,
 * response register
 */

`timescale 1ns/1ps

module ccm_result (
   input  logic                      clk,
   input  logic                      rst_l,
   input  ccm_ecc_pkg::ccm_exe_pkt_t exe,
   output ccm_ecc_pkg::ccm_rsp_t     rsp
);

   localparam int DW = ccm_ecc_pkg::DATA_W;
   localparam int EW = ccm_ecc_pkg::ECC_W;
   localparam int CW = ccm_ecc_pkg::CW_W;

   logic [EW-1:0] ecc_calc;
   logic [EW-1:0] syn;
   logic [CW-1:0] pos_vec;    // codeword in hamming position order
   logic [CW-1:0] err_mask;
   logic [CW-1:0] fixed_vec;
   logic [DW-1:0] data_fix;
   logic          single_err;
   logic          double_err;

   assign ecc_calc = ccm_ecc_pkg::ccm_ecc_gen(exe.cw.data);

   // bit 6 is the overall parity over the whole stored word
   assign syn = {^exe.cw, ecc_calc[EW-2:0] ^ exe.cw.ecc[EW-2:0]};

   assign single_err = (syn != '0) &  syn[EW-1];
   assign double_err = (syn != '0) & ~syn[EW-1];

   // position p of the code sits at bit p-1
   assign pos_vec = {exe.cw.ecc[6], exe.cw.data[31:26], exe.cw.ecc[5],
                     exe.cw.data[25:11], exe.cw.ecc[4], exe.cw.data[10:4],
                     exe.cw.ecc[3], exe.cw.data[3:1], exe.cw.ecc[2],
                     exe.cw.data[0], exe.cw.ecc[1:0]};

   always_comb begin
      for (int i = 0; i < CW; i++)
         err_mask[i] = (syn[EW-2:0] == 6'(i + 1));
   end

   // an error on the parity bit alone leaves the mask empty
   assign fixed_vec = single_err ? (pos_vec ^ err_mask) : pos_vec;

   assign data_fix = {fixed_vec[37:32], fixed_vec[30:16], fixed_vec[14:8],
                      fixed_vec[6:4], fixed_vec[2]};

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rsp <= '0;
      end else begin
         rsp.valid      <= exe.valid;
         rsp.fault      <= exe.fault;
         rsp.region     <= exe.region;
         // no array access behind a fault, so nothing to flag
         rsp.single_err <= exe.valid & ~exe.fault & single_err;
         rsp.double_err <= exe.valid & ~exe.fault & double_err;
         rsp.rdata      <= exe.fault ? '0 : data_fix;   // uncorrected on a double error
      end
   end

endmodule : ccm_result

/* ccm_tb.sv */
/*
 * testbench for the memory access path
 * clock and reset, seeded random loads and stores with flip masks,
 * reference model with a queue of expected responses, timeout
 */

`timescale 1ns/1ps

module ccm_tb;

   localparam int RST_CYC = 16;
   localparam int N_FILL  = 16;
   localparam int N_RAND  = 400;
   localparam int LATENCY = 3;
   localparam int MAX_CYC = RST_CYC + N_FILL + N_RAND + LATENCY + 50;
   localparam int MB      = ccm_map_pkg::MASK_BITS;
   localparam int CW      = ccm_ecc_pkg::CW_W;
   localparam logic [31:0] SADR = ccm_map_pkg::CCM_SADR;

   typedef struct packed {
      int                    due;         // cycle count when the response must show
      logic                  skip_data;   // rdata undefined on a double error
      ccm_ecc_pkg::ccm_rsp_t rsp;
   } exp_t;

   logic                  clk;
   logic                  rst_l;
   ccm_ecc_pkg::ccm_req_t req;
   ccm_ecc_pkg::ccm_rsp_t rsp;

   // reference model state
   logic [31:0] model_mem [0:15];
   int          model_flips [0:15];   // set bits in the last store's flip mask
   exp_t        exp_q [$];

   int seed;
   int cyc    = 0;
   int errors = 0;
   int n_rsp  = 0;

   ccm_top dut0 (
      .clk   (clk),
      .rst_l (rst_l),
      .req   (req),
      .rsp   (rsp)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= MAX_CYC) begin
         $display("timeout after %0d cycles, %0d responses still pending", cyc, exp_q.size());
         $display("sim failed");
         $finish;
      end
   end

   function automatic int rand_below(input int n);
      return ($random(seed) & 32'h7fff_ffff) % n;
   endfunction

   // 0, 1 or 2 distinct bits set
   function automatic logic [CW-1:0] make_flip(input int nbits);
      int            b0;
      int            b1;
      logic [CW-1:0] f;
      f  = '0;
      b0 = rand_below(CW);
      b1 = (b0 + 1 + rand_below(CW - 1)) % CW;
      if (nbits >= 1)
         f[b0] = 1'b1;
      if (nbits >= 2)
         f[b1] = 1'b1;
      return f;
   endfunction

   // about one in five addresses lands outside the window
   function automatic logic [31:0] pick_addr();
      int          r;
      logic [31:0] a;
      r = rand_below(10);
      a = $random(seed);
      if (r == 0)
         return a;
      if (r == 1)
         return {4'hF, a[27:0]};   // same region, almost always out of range
      return {SADR[31:16], a[15:0]};
   endfunction

   task automatic compare_field(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
      assert (got === exp) else begin
         errors++;
         $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   // sampled at the falling edge, one call per cycle
   task automatic watch_rsp();
      exp_t e;
      if (exp_q.size() > 0) begin
         assert (exp_q[0].due >= cyc) else begin
            errors++;
            $display("missing response: nothing came out at cycle %0d", exp_q[0].due);
            void'(exp_q.pop_front());
         end
      end
      if (rsp.valid === 1'b1) begin
         n_rsp++;
         assert (exp_q.size() > 0 && exp_q[0].due == cyc) else begin
            errors++;
            $display("unexpected response at %0t, no request due at cycle %0d", $time, cyc);
         end
         if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            compare_field("rsp.fault", e.rsp.fault, rsp.fault);
            compare_field("rsp.region", e.rsp.region, rsp.region);
            compare_field("rsp.single_err", e.rsp.single_err, rsp.single_err);
            compare_field("rsp.double_err", e.rsp.double_err, rsp.double_err);
            if (!e.skip_data)
               compare_field("rsp.rdata", e.rsp.rdata, rsp.rdata);
         end
      end
   endtask

   task automatic issue(input logic store, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [CW-1:0] flip);
      logic [11:0] off;
      logic [31:0] rs1;
      logic [31:0] ea;
      logic [3:0]  idx;
      logic        in_range;
      exp_t        e;
      off = 12'($random(seed));
      rs1 = addr - {{20{off[11]}}, off};   // random split exercises carry and borrow
      @(negedge clk);
      watch_rsp();
      req.valid  = 1'b1;
      req.store  = store;
      req.rs1    = rs1;
      req.offset = off;
      req.wdata  = wdata;
      req.flip   = flip;

      ea       = rs1 + {{20{off[11]}}, off};
      idx      = ea[5:2];
      in_range = (ea[31:MB] == SADR[31:MB]);
      e            = '0;
      e.due        = cyc + LATENCY;
      e.rsp.valid  = 1'b1;
      e.rsp.fault  = ~in_range;
      e.rsp.region = (ea[31:28] == SADR[31:28]);
      if (!in_range) begin
         exp_q.push_back(e);   // faulting store leaves the model untouched
      end else if (store) begin
         model_mem[idx]   = wdata;
         model_flips[idx] = $countones(flip);
      end else begin
         e.rsp.rdata      = model_mem[idx];
         e.rsp.single_err = (model_flips[idx] == 1);
         e.rsp.double_err = (model_flips[idx] == 2);
         e.skip_data      = (model_flips[idx] == 2);
         exp_q.push_back(e);
      end
   endtask

   task automatic idle_cycle();
      @(negedge clk);
      watch_rsp();
      req = '0;
   endtask

   initial begin
      logic [31:0] a;
      seed  = 82052;
      rst_l = 1'b0;
      req   = '0;
      repeat (RST_CYC) begin
         @(negedge clk);
         compare_field("rsp.valid", 32'd0, rsp.valid);
      end
      rst_l = 1'b1;

      // fill every word, aliased upper bits and byte bits vary
      for (int i = 0; i < N_FILL; i++) begin
         a = $random(seed);
         issue(1'b1, {SADR[31:16], a[15:6], 4'(i), a[1:0]}, $random(seed), '0);
      end

      for (int i = 0; i < N_RAND; i++) begin
         issue(rand_below(10) < 4, pick_addr(), $random(seed), make_flip(rand_below(3)));
      end

      repeat (LATENCY + 4)
         idle_cycle();

      $display("errors: %0d, responses seen: %0d", errors, n_rsp);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule : ccm_tb

/* ccm_tb_props.sv */
/*
 * concurrent checks on the memory path responses
 * bound into the top level
 */

`timescale 1ns/1ps

module ccm_props (
   input logic                      clk,
   input logic                      rst_l,
   input ccm_ecc_pkg::ccm_req_t     req,
   input ccm_ecc_pkg::ccm_dec_pkt_t dec,
   input ccm_ecc_pkg::ccm_rsp_t     rsp
);

   // a word is either corrected or flagged uncorrectable
   flags_exclusive: assert property (@(posedge clk) disable iff (!rst_l)
      !(rsp.single_err && rsp.double_err))
      else $error("single_err and double_err set together");

   fault_no_flags: assert property (@(posedge clk) disable iff (!rst_l)
      (rsp.valid && rsp.fault) |-> !(rsp.single_err || rsp.double_err))
      else $error("fault response carries an ECC flag");

   load_rsp: assert property (@(posedge clk) disable iff (!rst_l)
      (req.valid && !req.store) |-> ##3 rsp.valid)
      else $error("load not answered three cycles later");

   // fault is only known after decode, one cycle into the pipe
   fault_rsp: assert property (@(posedge clk) disable iff (!rst_l)
      (dec.valid && dec.fault) |-> ##2 rsp.valid)
      else $error("faulting request not answered three cycles later");

endmodule : ccm_props

bind ccm_top ccm_props props0 (
   .clk   (clk),
   .rst_l (rst_l),
   .req   (req),
   .dec   (dec),
   .rsp   (rsp)
);

/* ccm_top.sv */
/*
 * memory access path top level
 * decode, execute and result stages, three cycles request to response
 */

`timescale 1ns/1ps

module ccm_top (
   input  logic                  clk,
   input  logic                  rst_l,
   input  ccm_ecc_pkg::ccm_req_t req,
   output ccm_ecc_pkg::ccm_rsp_t rsp
);

   ccm_ecc_pkg::ccm_dec_pkt_t dec;   // decode -> execute
   ccm_ecc_pkg::ccm_exe_pkt_t exe;   // execute -> result

   ccm_decode dec0 (
      .clk   (clk),
      .rst_l (rst_l),
      .req   (req),
      .dec   (dec)
   );

   ccm_execute exe0 (
      .clk   (clk),
      .rst_l (rst_l),
      .dec   (dec),
      .exe   (exe)
   );

   ccm_result res0 (
      .clk   (clk),
      .rst_l (rst_l),
      .exe   (exe),
      .rsp   (rsp)
   );

endmodule : ccm_top

/* sources.f */
ccm_map_pkg.sv
ccm_ecc_pkg.sv
ccm_decode.sv
ccm_execute.sv
ccm_result.sv
ccm_top.sv
ccm_tb_props.sv
ccm_tb.sv
